// File: build.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/branch_req_if.sv
verilog/int_alu.sv
verilog/shift_unit.sv
verilog/branch_unit.sv
verilog/exec_pipeline.sv
test/exec_checker.sv
test/exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execution stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module exec_tb -f build.f -o exec_sim \
    && ./obj_dir/exec_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

// File: test/exec_checker.sv
// testbench checker for the execution stage
// watches write-back and branch outputs, pops expected records from
// queues that the testbench fills at issue, and counts errors

module exec_checker (
    input logic        clk,
    input logic        reset,
    input logic        wb_valid,
    input logic [1:0]  wb_id,
    input logic [31:0] wb_pc,
    input logic        wb_rd_en,
    input logic [4:0]  wb_rd_idx,
    input logic [31:0] wb_rd_val,
    input logic        branch_valid,
    input logic [1:0]  branch_id,
    input logic [31:0] branch_pc,
    input logic [31:0] branch_old_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    // val is rd_val for a write-back and the target for a branch
    typedef struct packed {
        logic [31:0] due;
        logic [1:0]  id;
        logic        rd_en;
        logic [4:0]  rd_idx;
        logic [31:0] pc;
        logic [31:0] val;
    } exp_t;

    exp_t wb_q[$];
    exp_t br_q[$];
    int   errors = 0;
    int   edge_count = 0;
    int   wb_age = 0;
    int   br_age = 0;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    // issue is taken at the next rising edge
    task automatic expect_wb(input logic [1:0] id, input logic rd_en,
                             input logic [4:0] rd_idx, input logic [31:0] pc,
                             input logic [31:0] rd_val);
        exp_t e;
        e.due    = edge_count + 3;
        e.id     = id;
        e.rd_en  = rd_en;
        e.rd_idx = rd_idx;
        e.pc     = pc;
        e.val    = rd_val;
        wb_q.push_back(e);
    endtask

    task automatic expect_branch(input logic [1:0] id, input logic [31:0] old_pc,
                                 input logic [31:0] target);
        exp_t e;
        e.due    = edge_count + 2;
        e.id     = id;
        e.rd_en  = 1'b0;
        e.rd_idx = '0;
        e.pc     = old_pc;
        e.val    = target;
        br_q.push_back(e);
    endtask

    task automatic compare(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin : watch
        exp_t exp;
        if (reset) begin
            if (wb_valid || branch_valid) begin
                $display("valid output raised during reset at %0t", $time);
                errors++;
            end
        end else begin
            if (wb_valid) begin
                if (wb_q.size() == 0) begin
                    $display("unexpected write-back at %0t for pc %h", $time, wb_pc);
                    errors++;
                end else begin
                    exp = wb_q.pop_front();
                    compare("wb_valid edge", exp.due, edge_count);
                    compare("wb_id", 32'(exp.id), 32'(wb_id));
                    compare("wb_pc", exp.pc, wb_pc);
                    compare("wb_rd_en", 32'(exp.rd_en), 32'(wb_rd_en));
                    compare("wb_rd_idx", 32'(exp.rd_idx), 32'(wb_rd_idx));
                    compare("wb_rd_val", exp.val, wb_rd_val);
                end
            end
            if (branch_valid) begin
                if (br_q.size() == 0) begin
                    $display("unexpected branch at %0t from pc %h", $time, branch_old_pc);
                    errors++;
                end else begin
                    exp = br_q.pop_front();
                    compare("branch_valid edge", exp.due, edge_count);
                    compare("branch_id", 32'(exp.id), 32'(branch_id));
                    compare("branch_old_pc", exp.pc, branch_old_pc);
                    compare("branch_pc", exp.val, branch_pc);
                end
            end

            // oldest expected event must show up within 20 cycles
            if (wb_q.size() == 0 || wb_valid) begin
                wb_age = 0;
            end else begin
                wb_age++;
            end
            if (wb_age > 20) begin
                $display("timeout: write-back for pc %h never arrived", wb_q[0].pc);
                errors++;
                void'(wb_q.pop_front());
                wb_age = 0;
            end
            if (br_q.size() == 0 || branch_valid) begin
                br_age = 0;
            end else begin
                br_age++;
            end
            if (br_age > 20) begin
                $display("timeout: branch from pc %h never arrived", br_q[0].pc);
                errors++;
                void'(br_q.pop_front());
                br_age = 0;
            end
        end
    end

endmodule

// File: test/exec_stim.txt
# id ph pc rd_en rd_idx rd_val rs1 rs2 sel sub imm_en imm lop shl sha br bop btgt
# then expected: wb rd_val br target (all hex)
0 0 00000100 1 01 00000000 00000005 00000007 1 0 0 00000000 0 0 0 0 0 00000000 1 0000000c 0 00000000
1 0 00000104 1 02 00000000 00000003 00000005 1 1 0 00000000 0 0 0 0 0 00000000 1 fffffffe 0 00000000
2 0 00000108 1 03 00000000 ffffffff 00000000 1 0 1 00000002 0 0 0 0 0 00000000 1 00000001 0 00000000
3 0 0000010c 1 04 00000000 f0f0f0f0 0ff00ff0 2 0 0 00000000 0 0 0 0 0 00000000 1 ff00ff00 0 00000000
0 0 00000110 1 05 00000000 f0f0f0f0 0ff00ff0 2 0 0 00000000 2 0 0 0 0 00000000 1 fff0fff0 0 00000000
1 0 00000114 1 06 00000000 f0f0f0f0 00000000 2 0 1 0000ffff 3 0 0 0 0 00000000 1 0000f0f0 0 00000000
2 0 00000118 1 07 00000000 00000003 00000000 3 0 1 00000004 0 1 0 0 0 00000000 1 00000030 0 00000000
3 0 0000011c 1 08 00000000 80000000 00000024 3 0 0 00000000 0 0 0 0 0 00000000 1 08000000 0 00000000
0 0 00000120 1 09 00000000 80000000 00000000 3 0 1 00000008 0 0 1 0 0 00000000 1 ff800000 0 00000000
1 0 00000124 1 0a 00000000 7ffffff0 00000024 3 0 0 00000000 0 0 1 0 0 00000000 1 07ffffff 0 00000000
0 0 00000200 0 00 00000000 00000001 00000002 0 0 0 00000000 0 0 0 1 0 00000300 1 00000000 0 00000000
1 0 00000204 0 00 00000000 00000001 00000002 0 0 0 00000000 0 0 0 1 1 00000304 1 00000000 1 00000304
1 0 00000208 1 0b 00000000 00000001 00000001 1 0 0 00000000 0 0 0 1 2 00000400 0 00000000 0 00000000
1 1 0000020c 1 0c 00000000 00000010 00000020 1 0 0 00000000 0 0 0 0 0 00000000 1 00000030 0 00000000
0 0 00000210 1 0d 00000000 00000001 00000001 1 0 0 00000000 0 0 0 0 0 00000000 1 00000002 0 00000000
2 0 00000214 0 00 00000000 ffffffff 00000001 0 0 0 00000000 0 0 0 1 4 00000500 1 00000000 1 00000500
2 1 00000218 0 00 00000000 ffffffff 00000001 0 0 0 00000000 0 0 0 1 5 00000510 1 00000000 0 00000000
2 1 0000021c 0 00 00000000 ffffffff 00000001 0 0 0 00000000 0 0 0 1 6 00000520 1 00000000 0 00000000
2 1 00000220 0 00 00000000 ffffffff 00000001 0 0 0 00000000 0 0 0 1 7 00000600 1 00000000 1 00000600
3 0 00000224 0 00 00000000 00000005 00000005 0 0 0 00000000 0 0 0 1 0 00000700 1 00000000 1 00000700
0 0 00000228 1 01 0000022c 00000000 00000000 0 0 0 00000000 0 0 0 1 2 00000800 1 0000022c 1 00000800
0 1 0000022c 1 01 00000230 00001001 00000000 0 0 1 00000004 0 0 0 1 3 00000000 1 00000230 1 00001004
3 1 00000230 0 00 00000000 00000005 00000005 0 0 0 00000000 0 0 0 1 1 00000710 1 00000000 0 00000000
3 1 00000234 0 00 00000000 00000005 ffffffff 0 0 0 00000000 0 0 0 1 5 00000900 1 00000000 1 00000900
1 1 00000238 0 00 00000000 00000001 ffffffff 0 0 0 00000000 0 0 0 1 6 00000a00 1 00000000 1 00000a00
0 0 00000240 1 0e 00000000 00000100 00000001 1 0 0 00000000 0 0 0 0 0 00000000 1 00000101 0 00000000
1 0 00000244 1 0f 00000000 00000200 00000002 1 0 0 00000000 0 0 0 0 0 00000000 1 00000202 0 00000000
2 0 00000248 1 10 00000000 00000300 00000003 1 0 0 00000000 0 0 0 0 0 00000000 1 00000303 0 00000000
3 0 0000024c 1 11 00000000 00000400 00000004 1 0 0 00000000 0 0 0 0 0 00000000 1 00000404 0 00000000
2 1 00000250 1 12 00000000 00000001 00000001 1 0 0 00000000 0 0 0 0 0 00000000 0 00000000 0 00000000

// File: test/exec_tb.sv
// testbench for the integer execution stage
// reads issue records and expected results from the stimulus file,
// drives them on the falling edge with random idle gaps

module exec_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import exec_pkg::*;

    logic        clk;
    logic        reset;
    logic        issue_valid;
    tid_t        issue_id;
    logic        issue_phase;
    pc_t         issue_pc;
    logic        issue_rd_en;
    ridx_t       issue_rd_idx;
    rval_t       issue_rd_val;
    rval_t       issue_rs1_val;
    rval_t       issue_rs2_val;
    result_sel_t issue_sel;
    logic        issue_sub;
    logic        issue_imm_en;
    rval_t       issue_imm_val;
    logic_op_t   issue_logic_op;
    logic        issue_shift_left;
    logic        issue_shift_arith;
    logic        issue_branch;
    branch_op_t  issue_branch_op;
    pc_t         issue_branch_target;
    logic        branch_valid;
    tid_t        branch_id;
    pc_t         branch_pc;
    pc_t         branch_old_pc;
    logic        wb_valid;
    tid_t        wb_id;
    pc_t         wb_pc;
    logic        wb_rd_en;
    ridx_t       wb_rd_idx;
    rval_t       wb_rd_val;

    integer      seed;
    int          tb_errors;
    logic [31:0] f[0:21];

    exec_pipeline i_dut (.*);

    exec_checker u_checker (
        .clk, .reset, .wb_valid, .wb_id, .wb_pc, .wb_rd_en, .wb_rd_idx, .wb_rd_val,
        .branch_valid, .branch_id, .branch_pc, .branch_old_pc
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive_record();
        // occasional idle cycle between issues
        if (($random(seed) & 3) == 0) begin
            @(negedge clk);
            issue_valid = 1'b0;
        end
        @(negedge clk);
        issue_valid         = 1'b1;
        issue_id            = f[0][1:0];
        issue_phase         = f[1][0];
        issue_pc            = f[2];
        issue_rd_en         = f[3][0];
        issue_rd_idx        = f[4][4:0];
        issue_rd_val        = f[5];
        issue_rs1_val       = f[6];
        issue_rs2_val       = f[7];
        issue_sel           = result_sel_t'(f[8][1:0]);
        issue_sub           = f[9][0];
        issue_imm_en        = f[10][0];
        issue_imm_val       = f[11];
        issue_logic_op      = logic_op_t'(f[12][1:0]);
        issue_shift_left    = f[13][0];
        issue_shift_arith   = f[14][0];
        issue_branch        = f[15][0];
        issue_branch_op     = branch_op_t'(f[16][2:0]);
        issue_branch_target = f[17];
        if (f[18][0]) begin
            u_checker.expect_wb(f[0][1:0], f[3][0], f[4][4:0], f[2], f[19]);
        end
        if (f[20][0]) begin
            u_checker.expect_branch(f[0][1:0], f[2], f[21]);
        end
    endtask

    initial begin : main
        int    fd;
        int    cycles;
        int    total;
        string line;
        seed = 32'h8fcb5264;
        tb_errors = 0;
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_id = '0;
        issue_phase = 1'b0;
        issue_pc = '0;
        issue_rd_en = 1'b0;
        issue_rd_idx = '0;
        issue_rd_val = '0;
        issue_rs1_val = '0;
        issue_rs2_val = '0;
        issue_sel = RES_PASS;
        issue_sub = 1'b0;
        issue_imm_en = 1'b0;
        issue_imm_val = '0;
        issue_logic_op = LOGIC_XOR;
        issue_shift_left = 1'b0;
        issue_shift_arith = 1'b0;
        issue_branch = 1'b0;
        issue_branch_op = BR_EQ;
        issue_branch_target = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // idle stretch, outputs must stay low
        repeat (5) @(negedge clk);

        fd = $fopen("test/exec_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16],
                                f[17], f[18], f[19], f[20], f[21]) == 22) begin
                        drive_record();
                    end
                end
            end
            $fclose(fd);
        end
        @(negedge clk);
        issue_valid = 1'b0;

        cycles = 0;
        while ((u_checker.wb_q.size() != 0 || u_checker.br_q.size() != 0) && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (u_checker.wb_q.size() != 0 || u_checker.br_q.size() != 0) begin
            $display("expected events still outstanding at the end of the run");
            tb_errors++;
        end
        // catch any stray event after the last expected one
        repeat (5) @(negedge clk);

        total = tb_errors + u_checker.errors;
        $display("error count: %0d", total);
        if (total == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #200us;
        $display("simulation watchdog expired");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog/branch_req_if.sv
// stage-0 branch request, from the pipeline registers and ALU flags
// to the branch unit; no handshake, valid qualifies one cycle

interface branch_req_if;
    import exec_pkg::*;

    tid_t       id;
    logic       phase;
    pc_t        pc;
    branch_op_t op;
    logic       eq;
    logic       lt;
    logic       ltu;
    pc_t        jalr_target;
    pc_t        imm_target;
    logic       valid;

    modport src (
        output id, phase, pc, op, eq, lt, ltu, jalr_target, imm_target, valid
    );

    modport dst (
        input id, phase, pc, op, eq, lt, ltu, jalr_target, imm_target, valid
    );

endinterface

// File: verilog/branch_unit.sv
// branch resolution for stage 1
// evaluates the condition, picks the target and keeps one phase bit per
// thread; a taken branch flips its thread's bit so younger work is killed

`include "exec_consts.svh"

module branch_unit (
    input  logic                     clk,
    input  logic                     reset,
    branch_req_if.dst                req,
    output logic [`EXEC_THREADS-1:0] phase_table,
    output logic                     branch_valid,
    output exec_pkg::tid_t           branch_id,
    output exec_pkg::pc_t            branch_pc,
    output exec_pkg::pc_t            branch_old_pc
);
    import exec_pkg::*;

    logic phase_ok;
    logic cond;
    logic taken;
    pc_t  target;

    assign phase_ok = (req.phase == phase_table[req.id]);

    always_comb begin
        case (req.op)
            BR_EQ:   cond = req.eq;
            BR_NE:   cond = !req.eq;
            BR_LT:   cond = req.lt;
            BR_GE:   cond = !req.lt;
            BR_LTU:  cond = req.ltu;
            BR_GEU:  cond = !req.ltu;
            default: cond = 1'b1;
        endcase
    end

    assign taken = req.valid && phase_ok && cond;

    // jalr drops bit 0 of rs1 + imm
    assign target = (req.op == BR_JALR) ? {req.jalr_target[`EXEC_PC_BITS-1:1], 1'b0}
                                        : req.imm_target;

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_valid <= 1'b0;
            phase_table  <= '0;
        end else begin
            branch_valid <= taken;
            if (taken) begin
                phase_table[req.id] <= ~phase_table[req.id];
            end
        end
    end

    always_ff @(posedge clk) begin
        branch_id     <= req.id;
        branch_pc     <= target;
        branch_old_pc <= req.pc;
    end

    // branch targets are always halfword aligned
    a_target_aligned : assert property (
        @(posedge clk) disable iff (reset) branch_valid |-> !branch_pc[0]
    );

endmodule

// File: verilog/exec_consts.svh
// widths and counts shared by the integer execution stage
// include wherever a width or thread count is needed

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// data path width
`define EXEC_XLEN 32

// hardware threads and the id that selects one
`define EXEC_THREADS 4
`define EXEC_ID_BITS 2

// program counter width
`define EXEC_PC_BITS 32

// shift amount, log2 of the data width
`define EXEC_SHAMT_BITS 5

`endif

// File: verilog/exec_pipeline.sv
// integer execution stage of the multi-threaded core, top level
// takes one decoded instruction per cycle while issue_valid is high;
// branch result after 2 edges, write-back after 3, stale phases killed

`include "exec_consts.svh"

module exec_pipeline (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  exec_pkg::tid_t        issue_id,
    input  logic                  issue_phase,
    input  exec_pkg::pc_t         issue_pc,
    input  logic                  issue_rd_en,
    input  exec_pkg::ridx_t       issue_rd_idx,
    input  exec_pkg::rval_t       issue_rd_val,
    input  exec_pkg::rval_t       issue_rs1_val,
    input  exec_pkg::rval_t       issue_rs2_val,
    input  exec_pkg::result_sel_t issue_sel,
    input  logic                  issue_sub,
    input  logic                  issue_imm_en,
    input  exec_pkg::rval_t       issue_imm_val,
    input  exec_pkg::logic_op_t   issue_logic_op,
    input  logic                  issue_shift_left,
    input  logic                  issue_shift_arith,
    input  logic                  issue_branch,
    input  exec_pkg::branch_op_t  issue_branch_op,
    input  exec_pkg::pc_t         issue_branch_target,
    output logic                  branch_valid,
    output exec_pkg::tid_t        branch_id,
    output exec_pkg::pc_t         branch_pc,
    output exec_pkg::pc_t         branch_old_pc,
    output logic                  wb_valid,
    output exec_pkg::tid_t        wb_id,
    output exec_pkg::pc_t         wb_pc,
    output logic                  wb_rd_en,
    output exec_pkg::ridx_t       wb_rd_idx,
    output exec_pkg::rval_t       wb_rd_val
);
    import exec_pkg::*;

    issue_t                   issue_in;
    issue_t                   st0;
    rval_t                    adder_val;
    rval_t                    logic_val;
    logic                     alu_eq;
    logic                     alu_lt;
    logic                     alu_ltu;
    rval_t                    shift_val;
    logic [`EXEC_THREADS-1:0] phase_table;
    logic                     keep;

    assign issue_in = '{
        valid: issue_valid, id: issue_id, phase: issue_phase, pc: issue_pc,
        rd_en: issue_rd_en, rd_idx: issue_rd_idx, rd_val: issue_rd_val,
        rs1_val: issue_rs1_val, rs2_val: issue_rs2_val, sel: issue_sel,
        sub: issue_sub, imm_en: issue_imm_en, imm_val: issue_imm_val,
        logic_op: issue_logic_op, shift_left: issue_shift_left,
        shift_arith: issue_shift_arith, branch: issue_branch,
        branch_op: issue_branch_op, branch_target: issue_branch_target
    };

    // ----------------------------------------
    // stage 0
    // ----------------------------------------

    always_ff @(posedge clk) begin
        st0 <= issue_in;
        if (reset) begin
            st0.valid <= 1'b0;
        end
    end

    int_alu u_alu (
        .clk, .reset, .issue(issue_in), .adder_val, .logic_val,
        .eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
    );

    // ----------------------------------------
    // stage 1
    // ----------------------------------------

    branch_req_if breq ();

    assign breq.id          = st0.id;
    assign breq.phase       = st0.phase;
    assign breq.pc          = st0.pc;
    assign breq.op          = st0.branch_op;
    assign breq.eq          = alu_eq;
    assign breq.lt          = alu_lt;
    assign breq.ltu         = alu_ltu;
    assign breq.jalr_target = pc_t'(adder_val);
    assign breq.imm_target  = st0.branch_target;
    assign breq.valid       = st0.valid && st0.branch;

    branch_unit u_branch (
        .clk, .reset, .req(breq), .phase_table,
        .branch_valid, .branch_id, .branch_pc, .branch_old_pc
    );

    shift_unit u_shift (
        .clk, .reset, .val(st0.rs1_val),
        .shamt(st0.imm_en ? st0.imm_val[`EXEC_SHAMT_BITS-1:0]
                          : st0.rs2_val[`EXEC_SHAMT_BITS-1:0]),
        .left(st0.shift_left), .arith(st0.shift_arith), .result(shift_val)
    );

    // stale phase means an older branch of this thread was taken
    assign keep = st0.valid && (st0.phase == phase_table[st0.id]);

    logic  st1_valid;
    tid_t  st1_id;
    pc_t   st1_pc;
    logic  st1_rd_en;
    ridx_t st1_rd_idx;
    rval_t st1_rd_val;
    logic  st1_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
        end else begin
            st1_valid <= keep;
        end
    end

    always_ff @(posedge clk) begin
        st1_id     <= st0.id;
        st1_pc     <= st0.pc;
        st1_rd_en  <= st0.rd_en && keep;
        st1_rd_idx <= st0.rd_idx;
        st1_shift  <= (st0.sel == RES_SHIFTER);
        case (st0.sel)
            RES_ADDER:   st1_rd_val <= adder_val;
            RES_LOGICAL: st1_rd_val <= logic_val;
            default:     st1_rd_val <= st0.rd_val;
        endcase
    end

    // ----------------------------------------
    // stage 2, write-back
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= st1_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_id     <= st1_id;
        wb_pc     <= st1_pc;
        wb_rd_en  <= st1_rd_en;
        wb_rd_idx <= st1_rd_idx;
        wb_rd_val <= st1_shift ? shift_val : st1_rd_val;
    end

    a_wb_rd_en_known : assert property (
        @(posedge clk) disable iff (reset) $rose(wb_valid) |-> !$isunknown(wb_rd_en)
    );

endmodule

// File: verilog/exec_pkg.sv
// types shared by the execution stage modules
// holds the value types, the opcode enums and the packed issue record

`include "exec_consts.svh"

package exec_pkg;

    typedef logic signed [`EXEC_XLEN-1:0] rval_t;
    typedef logic [`EXEC_PC_BITS-1:0] pc_t;
    typedef logic [`EXEC_ID_BITS-1:0] tid_t;
    typedef logic [4:0] ridx_t;

    // write-back source
    typedef enum logic [1:0] {
        RES_PASS    = 2'd0,
        RES_ADDER   = 2'd1,
        RES_LOGICAL = 2'd2,
        RES_SHIFTER = 2'd3
    } result_sel_t;

    // low bits of funct3
    typedef enum logic [1:0] {
        LOGIC_XOR = 2'b00,
        LOGIC_OR  = 2'b10,
        LOGIC_AND = 2'b11
    } logic_op_t;

    typedef enum logic [2:0] {
        BR_EQ   = 3'b000,
        BR_NE   = 3'b001,
        BR_JAL  = 3'b010,
        BR_JALR = 3'b011,
        BR_LT   = 3'b100,
        BR_GE   = 3'b101,
        BR_LTU  = 3'b110,
        BR_GEU  = 3'b111
    } branch_op_t;

    typedef struct packed {
        logic        valid;
        tid_t        id;
        logic        phase;
        pc_t         pc;
        logic        rd_en;
        ridx_t       rd_idx;
        rval_t       rd_val;
        rval_t       rs1_val;
        rval_t       rs2_val;
        result_sel_t sel;
        logic        sub;
        logic        imm_en;
        rval_t       imm_val;
        logic_op_t   logic_op;
        logic        shift_left;
        logic        shift_arith;
        logic        branch;
        branch_op_t  branch_op;
        pc_t         branch_target;
    } issue_t;

endpackage

// File: verilog/int_alu.sv
// stage-0 adder, logic unit and compare flags
// takes the issue record straight from the input and registers every
// result at the same edge as the stage-0 pipeline registers

module int_alu (
    input  logic             clk,
    input  logic             reset,
    input  exec_pkg::issue_t issue,
    output exec_pkg::rval_t  adder_val,
    output exec_pkg::rval_t  logic_val,
    output logic             eq,
    output logic             lt,
    output logic             ltu
);
    import exec_pkg::*;

    rval_t op_a;
    rval_t op_b;
    rval_t rs2;
    rval_t sum;
    rval_t logic_res;

    // ----------------------------------------
    // operands
    // ----------------------------------------

    assign op_a = issue.rs1_val;
    assign rs2  = issue.rs2_val;

    // immediate replaces rs2 for the adder and logic unit
    assign op_b = issue.imm_en ? issue.imm_val : rs2;

    // ----------------------------------------
    // adder and logic unit
    // ----------------------------------------

    // wraps modulo 2^XLEN
    assign sum = issue.sub ? op_a - op_b : op_a + op_b;

    always_comb begin
        case (issue.logic_op)
            LOGIC_XOR: logic_res = op_a ^ op_b;
            LOGIC_OR:  logic_res = op_a | op_b;
            LOGIC_AND: logic_res = op_a & op_b;
            default:   logic_res = op_a & op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        adder_val <= sum;
        logic_val <= logic_res;
    end

    // ----------------------------------------
    // compare flags
    // ----------------------------------------

    // always rs1 against rs2, never the immediate
    always_ff @(posedge clk) begin
        if (reset) begin
            eq  <= 1'b0;
            lt  <= 1'b0;
            ltu <= 1'b0;
        end else begin
            eq  <= (op_a == rs2);
            lt  <= (op_a < rs2);
            ltu <= ($unsigned(op_a) < $unsigned(rs2));
        end
    end

endmodule

// File: verilog/shift_unit.sv
// stage-1 barrel shifter
// shift amount is picked upstream from the immediate or rs2

`include "exec_consts.svh"

module shift_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  exec_pkg::rval_t             val,
    input  logic [`EXEC_SHAMT_BITS-1:0] shamt,
    input  logic                        left,
    input  logic                        arith,
    output exec_pkg::rval_t             result
);
    import exec_pkg::*;

    rval_t shifted;

    always_comb begin
        if (left) begin
            shifted = val << shamt;
        end else if (arith) begin
            // val is signed, so this fills with the sign bit
            shifted = val >>> shamt;
        end else begin
            shifted = rval_t'($unsigned(val) >> shamt);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else begin
            result <= shifted;
        end
    end

endmodule
